//--- Makefile
TOP := egress_pio_tb
LOG := sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory and the log"

obj_dir/V$(TOP): filelist.f rtl/*.sv test/*.sv
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f filelist.f

test: obj_dir/V$(TOP)
	-./obj_dir/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "Result: FAILED" $(LOG); then echo "simulation reported failure"; exit 1; fi
	@grep -q "Result: PASSED" $(LOG) || { echo "no pass line in $(LOG)"; exit 1; }

clean:
	rm -rf obj_dir $(LOG)

//--- filelist.f
rtl/egress_pkg.sv
rtl/pio_regs_pkg.sv
rtl/egress_ifs.sv
rtl/stream_fifo.sv
rtl/stream_width_packer.sv
rtl/egress_pio_regs.sv
rtl/pio_word_counter.sv
rtl/axil_pio_bridge.sv
rtl/egress_pio_top.sv
test/egress_pio_tb.sv

//--- rtl/axil_pio_bridge.sv
module axil_pio_bridge
    import pio_regs_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic        awvalid,
    output logic        awready,
    input  logic [31:0] awaddr,
    input  logic        wvalid,
    output logic        wready,
    input  logic [31:0] wdata,
    output logic        bvalid,
    input  logic        bready,
    output logic [1:0]  bresp,
    input  logic        arvalid,
    output logic        arready,
    input  logic [31:0] araddr,
    output logic        rvalid,
    input  logic        rready,
    output logic [31:0] rdata,
    output logic [1:0]  rresp,
    pio_ctrl_if.host    ctrl
);

    typedef enum logic [1:0] {
        IDLE,
        WRITE_RESP,
        READ_RESP
    } state_t;

    state_t state;
    logic   rd_go;
    logic   wr_go;

    // reads win when both are pending
    assign rd_go = (state == IDLE) && arvalid;
    assign wr_go = (state == IDLE) && !arvalid && awvalid && wvalid;

    assign arready = rd_go;
    assign awready = wr_go;
    assign wready  = wr_go;

    assign ctrl.ren   = rd_go;
    assign ctrl.raddr = araddr;
    assign ctrl.wen   = wr_go;
    assign ctrl.waddr = awaddr;
    assign ctrl.wdata = wdata;

    assign bvalid = state == WRITE_RESP;
    assign rvalid = state == READ_RESP;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= IDLE;
        end else begin
            case (state)
                IDLE: begin
                    if (rd_go) begin
                        state <= READ_RESP;
                    end else if (wr_go) begin
                        state <= WRITE_RESP;
                    end
                end
                WRITE_RESP: if (bready) state <= IDLE;
                READ_RESP:  if (rready) state <= IDLE;
                default:    state <= IDLE;
            endcase
        end
    end

    // response captured on the strobe cycle
    always_ff @(posedge clk) begin
        if (rd_go) begin
            rdata <= ctrl.rdata;
            rresp <= ctrl.rerr ? RESP_SLVERR : RESP_OKAY;
        end
        if (wr_go) begin
            bresp <= ctrl.werr ? RESP_SLVERR : RESP_OKAY;
        end
    end

    assert property (@(posedge clk) disable iff (rst)
        (ctrl.wen || ctrl.ren) |-> !(ctrl.wen && ctrl.ren) ##1 !(ctrl.wen || ctrl.ren));

endmodule

//--- rtl/egress_ifs.sv
interface word_stream_if
    import egress_pkg::*;
();

    logic      valid;
    logic      ready;
    pio_word_t word;

    modport source (
        output valid,
        output word,
        input  ready
    );

    modport sink (
        input  valid,
        input  word,
        output ready
    );

endinterface

// simple register bus, one-cycle wen/ren strobes
interface pio_ctrl_if ();

    logic        wen;
    logic [31:0] waddr;
    logic [31:0] wdata;
    logic        werr;
    logic        ren;
    logic [31:0] raddr;
    logic [31:0] rdata;
    logic        rerr;

    modport host (
        output wen, waddr, wdata, ren, raddr,
        input  werr, rdata, rerr
    );

    modport dev (
        input  wen, waddr, wdata, ren, raddr,
        output werr, rdata, rerr
    );

endinterface

//--- rtl/egress_pio_regs.sv
module egress_pio_regs
    import egress_pkg::*;
    import pio_regs_pkg::*;
#(
    parameter int COUNT_WIDTH = 16
) (
    input  logic                   clk,
    input  logic                   rst,
    input  logic [COUNT_WIDTH-1:0] word_count,
    input  logic [COUNT_WIDTH-1:0] last_count,
    output logic                   pop,
    output logic                   pop_last,
    output logic                   clear,
    pio_ctrl_if.dev                ctrl,
    word_stream_if.sink            words
);

    logic [2:0]  rd_idx;
    logic        rd_hi_ok;
    logic        rd_data_out;
    logic        wr_ctrl;
    pio_word_t   cur;
    logic [31:0] data_stat;

    assign rd_idx   = ctrl.raddr[4:2];
    assign rd_hi_ok = ctrl.raddr[31:5] == '0;

    // keep and last only show while a word is present
    assign cur = words.valid ? words.word : '0;

    always_comb begin
        data_stat = '0;
        data_stat[STAT_VALID_BIT] = words.valid;
        data_stat[STAT_LAST_BIT]  = cur.last;
        data_stat[STAT_KEEP_LSB +: WORD_BYTES] = cur.keep;
    end

    always_comb begin
        ctrl.rdata = '0;
        ctrl.rerr  = !rd_hi_ok;
        if (rd_hi_ok) begin
            case (rd_idx)
                REG_DATA_STAT[4:2]:  ctrl.rdata = data_stat;
                REG_DATA_OUT[4:2]:   ctrl.rdata = cur.data;
                REG_WORD_COUNT[4:2]: ctrl.rdata = 32'(word_count);
                REG_LAST_COUNT[4:2]: ctrl.rdata = 32'(last_count);
                default:             ctrl.rerr  = 1'b1;
            endcase
        end
    end

    // reading DATA_OUT consumes the word
    assign rd_data_out = rd_hi_ok && (rd_idx == REG_DATA_OUT[4:2]);
    assign words.ready = ctrl.ren && rd_data_out;
    assign pop         = words.valid && words.ready;
    assign pop_last    = pop && words.word.last;

    // CTRL is the only writable register
    assign wr_ctrl    = ctrl.waddr == REG_CTRL;
    assign ctrl.werr  = !wr_ctrl;
    assign clear      = ctrl.wen && wr_ctrl && ctrl.wdata[CTRL_CLEAR_BIT];

    // packer needs a fresh beat before the next word can appear
    assert property (@(posedge clk) disable iff (rst) pop |=> !words.valid);

endmodule

//--- rtl/egress_pio_top.sv
module egress_pio_top #(
    parameter int DATA_WIDTH  = 8,
    parameter int FIFO_DEPTH  = 16,
    parameter int COUNT_WIDTH = 16
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  stream_valid,
    input  logic [DATA_WIDTH-1:0] stream_data,
    output logic                  stream_ready,
    input  logic                  awvalid,
    output logic                  awready,
    input  logic [31:0]           awaddr,
    input  logic                  wvalid,
    output logic                  wready,
    input  logic [31:0]           wdata,
    output logic                  bvalid,
    input  logic                  bready,
    output logic [1:0]            bresp,
    input  logic                  arvalid,
    output logic                  arready,
    input  logic [31:0]           araddr,
    output logic                  rvalid,
    input  logic                  rready,
    output logic [31:0]           rdata,
    output logic [1:0]            rresp
);

    logic                            fifo_valid;
    logic                            fifo_ready;
    logic [DATA_WIDTH-1:0]           fifo_data;
    logic [$clog2(FIFO_DEPTH+1)-1:0] fifo_count;
    logic                            pop;
    logic                            pop_last;
    logic                            clear;
    logic [COUNT_WIDTH-1:0]          word_count;
    logic [COUNT_WIDTH-1:0]          last_count;

    word_stream_if words_if ();
    pio_ctrl_if    ctrl_if ();

    stream_fifo #(
        .WIDTH (DATA_WIDTH),
        .DEPTH (FIFO_DEPTH)
    ) fifo0 (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (stream_valid),
        .in_data   (stream_data),
        .in_ready  (stream_ready),
        .out_valid (fifo_valid),
        .out_ready (fifo_ready),
        .out_data  (fifo_data),
        .count     (fifo_count)
    );

    stream_width_packer #(
        .IN_WIDTH   (DATA_WIDTH),
        .FIFO_DEPTH (FIFO_DEPTH)
    ) packer0 (
        .clk        (clk),
        .rst        (rst),
        .in_valid   (fifo_valid),
        .in_data    (fifo_data),
        .fifo_count (fifo_count),
        .in_ready   (fifo_ready),
        .out        (words_if.source)
    );

    egress_pio_regs #(
        .COUNT_WIDTH (COUNT_WIDTH)
    ) regs0 (
        .clk        (clk),
        .rst        (rst),
        .word_count (word_count),
        .last_count (last_count),
        .pop        (pop),
        .pop_last   (pop_last),
        .clear      (clear),
        .ctrl       (ctrl_if.dev),
        .words      (words_if.sink)
    );

    pio_word_counter #(
        .COUNT_WIDTH (COUNT_WIDTH)
    ) counter0 (
        .clk        (clk),
        .rst        (rst),
        .pop        (pop),
        .pop_last   (pop_last),
        .clear      (clear),
        .word_count (word_count),
        .last_count (last_count)
    );

    axil_pio_bridge bridge0 (
        .clk     (clk),
        .rst     (rst),
        .awvalid (awvalid),
        .awready (awready),
        .awaddr  (awaddr),
        .wvalid  (wvalid),
        .wready  (wready),
        .wdata   (wdata),
        .bvalid  (bvalid),
        .bready  (bready),
        .bresp   (bresp),
        .arvalid (arvalid),
        .arready (arready),
        .araddr  (araddr),
        .rvalid  (rvalid),
        .rready  (rready),
        .rdata   (rdata),
        .rresp   (rresp),
        .ctrl    (ctrl_if.host)
    );

endmodule

//--- rtl/egress_pkg.sv
package egress_pkg;

    // bytes in one word handed to the host
    localparam int WORD_BYTES = 4;
    localparam int WORD_WIDTH = WORD_BYTES * 8;

    // first byte of the stream sits in data[7:0]
    // keep always grows upward from bit 0
    typedef struct packed {
        logic                  last;
        logic [WORD_BYTES-1:0] keep;
        logic [WORD_WIDTH-1:0] data;
    } pio_word_t;

endpackage

//--- rtl/pio_regs_pkg.sv
package pio_regs_pkg;

    // register map, byte offsets
    localparam logic [31:0] REG_DATA_STAT  = 32'h00;
    localparam logic [31:0] REG_DATA_OUT   = 32'h04;
    localparam logic [31:0] REG_WORD_COUNT = 32'h08;
    localparam logic [31:0] REG_LAST_COUNT = 32'h0C;
    localparam logic [31:0] REG_CTRL       = 32'h10;

    // DATA_STAT layout
    localparam int STAT_KEEP_LSB  = 0;
    localparam int STAT_LAST_BIT  = 4;
    localparam int STAT_VALID_BIT = 31;

    // CTRL bits
    localparam int CTRL_CLEAR_BIT = 0;

    // AXI response codes
    localparam logic [1:0] RESP_OKAY   = 2'b00;
    localparam logic [1:0] RESP_SLVERR = 2'b10;

endpackage

//--- rtl/pio_word_counter.sv
module pio_word_counter #(
    parameter int COUNT_WIDTH = 16
) (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   pop,
    input  logic                   pop_last,
    input  logic                   clear,
    output logic [COUNT_WIDTH-1:0] word_count,
    output logic [COUNT_WIDTH-1:0] last_count
);

    // clear takes priority over a pop in the same cycle
    always_ff @(posedge clk) begin
        if (rst || clear) begin
            word_count <= '0;
            last_count <= '0;
        end else begin
            if (pop) begin
                word_count <= word_count + 1'b1;
            end
            if (pop_last) begin
                last_count <= last_count + 1'b1;
            end
        end
    end

    assert property (@(posedge clk) disable iff (rst)
        $changed(last_count) && !$past(clear) |-> $changed(word_count));

endmodule

//--- rtl/stream_fifo.sv
module stream_fifo #(
    parameter int WIDTH = 8,
    parameter int DEPTH = 16
) (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       in_valid,
    input  logic [WIDTH-1:0]           in_data,
    output logic                       in_ready,
    output logic                       out_valid,
    input  logic                       out_ready,
    output logic [WIDTH-1:0]           out_data,
    output logic [$clog2(DEPTH+1)-1:0] count
);

    localparam int CNT_W = $clog2(DEPTH + 1);
    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

    logic [WIDTH-1:0] mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic             push;
    logic             pop;

    assign in_ready  = count != CNT_W'(DEPTH);
    assign out_valid = count != '0;
    assign out_data  = mem[rd_ptr];
    assign push      = in_valid && in_ready;
    assign pop       = out_valid && out_ready;

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= in_data;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            // push and pop together leave the count alone
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    assert property (@(posedge clk) disable iff (rst) count <= CNT_W'(DEPTH));

    // from empty only a push can move the count
    assert property (@(posedge clk) disable iff (rst)
        count == '0 |=> count <= CNT_W'(1));

endmodule

//--- rtl/stream_width_packer.sv
module stream_width_packer
    import egress_pkg::*;
#(
    parameter int IN_WIDTH   = 8,
    parameter int FIFO_DEPTH = 16
) (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            in_valid,
    input  logic [IN_WIDTH-1:0]             in_data,
    input  logic [$clog2(FIFO_DEPTH+1)-1:0] fifo_count,
    output logic                            in_ready,
    word_stream_if.source                   out
);

    localparam int IN_BYTES = IN_WIDTH / 8;
    localparam int BEATS    = WORD_BYTES / IN_BYTES;
    localparam int CNT_W    = $clog2(FIFO_DEPTH + 1);

    logic [1:0]            slot;
    logic                  word_valid;
    pio_word_t             word_q;
    logic                  take;
    logic                  beat_last;
    logic                  close;
    logic [WORD_BYTES-1:0] beat_keep;

    // hold off the fifo while a finished word waits for the host
    assign in_ready  = !word_valid;
    assign take      = in_valid && in_ready;
    assign beat_last = fifo_count == CNT_W'(1);
    assign close     = beat_last || (slot == 2'(BEATS - 1));
    assign beat_keep = WORD_BYTES'({IN_BYTES{1'b1}}) << (slot * IN_BYTES);

    assign out.valid = word_valid;
    assign out.word  = word_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            word_valid <= 1'b0;
            slot       <= '0;
        end else if (take) begin
            slot       <= close ? 2'd0 : slot + 2'd1;
            word_valid <= close;
        end else if (word_valid && out.ready) begin
            word_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            if (slot == '0) begin
                // first beat starts a fresh word
                word_q.data <= WORD_WIDTH'(in_data);
                word_q.keep <= beat_keep;
            end else begin
                word_q.data[slot*IN_WIDTH +: IN_WIDTH] <= in_data;
                word_q.keep <= word_q.keep | beat_keep;
            end
            word_q.last <= beat_last;
        end
    end

    assert property (@(posedge clk) disable iff (rst)
        out.valid && !out.ready |=> $stable(out.word));

endmodule

//--- test/egress_pio_tb.sv
module egress_pio_tb
    import egress_pkg::*;
    import pio_regs_pkg::*;
();
    timeunit 1ns;
    timeprecision 100ps;

    localparam int DATA_WIDTH   = 8;
    localparam int FIFO_DEPTH   = 16;
    localparam int COUNT_WIDTH  = 16;
    localparam int RESET_CYCLES = 16;
    localparam int NUM_BURSTS   = 20;
    localparam int NUM_ROWS     = 16;
    localparam int MAX_BYTES    = NUM_BURSTS * 11 + FIFO_DEPTH + 5;
    localparam int CYCLE_LIMIT  = 40 * (MAX_BYTES + NUM_ROWS) + RESET_CYCLES;

    typedef enum logic {OP_RD, OP_WR} op_e;
    typedef enum logic [1:0] {EXP_CONST, EXP_WORDS, EXP_LASTS} exp_e;
    typedef enum logic [1:0] {PRE_NONE, PRE_BURSTS, PRE_FILL} pre_e;

    // pre runs before the register operation of the row
    typedef struct packed {
        pre_e        pre;
        op_e         op;
        logic [31:0] addr;
        logic [31:0] wdata;
        logic [1:0]  resp;
        exp_e        kind;
        logic [31:0] data;
    } row_t;

    logic                   clk;
    logic                   rst;
    logic                   stream_valid;
    logic [DATA_WIDTH-1:0]  stream_data;
    logic                   stream_ready;
    logic                   awvalid;
    logic                   awready;
    logic [31:0]            awaddr;
    logic                   wvalid;
    logic                   wready;
    logic [31:0]            wdata;
    logic                   bvalid;
    logic                   bready;
    logic [1:0]             bresp;
    logic                   arvalid;
    logic                   arready;
    logic [31:0]            araddr;
    logic                   rvalid;
    logic                   rready;
    logic [31:0]            rdata;
    logic [1:0]             rresp;

    row_t                   rows [NUM_ROWS];
    logic [7:0]             pushed_q [$];
    logic [31:0]            rng_state = 32'h39cc77d3;
    logic [COUNT_WIDTH-1:0] words_popped = '0;
    logic [COUNT_WIDTH-1:0] lasts_popped = '0;

    egress_pio_top #(
        .DATA_WIDTH  (DATA_WIDTH),
        .FIFO_DEPTH  (FIFO_DEPTH),
        .COUNT_WIDTH (COUNT_WIDTH)
    ) dut0 (
        .clk (clk), .rst (rst),
        .stream_valid (stream_valid), .stream_data (stream_data),
        .stream_ready (stream_ready),
        .awvalid (awvalid), .awready (awready), .awaddr (awaddr),
        .wvalid (wvalid), .wready (wready), .wdata (wdata),
        .bvalid (bvalid), .bready (bready), .bresp (bresp),
        .arvalid (arvalid), .arready (arready), .araddr (araddr),
        .rvalid (rvalid), .rready (rready), .rdata (rdata), .rresp (rresp)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic logic [7:0] next_byte();
        rng_state = rng_state * 32'd1664525 + 32'd1013904223;
        return rng_state[23:16];
    endfunction

    task automatic stop_with_failure();
        $display("Result: FAILED");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_resp(input string name, input logic [1:0] got, input logic [1:0] exp);
        if (got !== exp) begin
            $display("MISMATCH %s: got 0x%h, expected 0x%h", name, got, exp);
            stop_with_failure();
        end
    endtask

    task automatic check_word(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("MISMATCH %s: got 0x%h, expected 0x%h", name, got, exp);
            stop_with_failure();
        end
    endtask

    task automatic check_keep(input string name,
                              input logic [WORD_BYTES-1:0] got_keep, input logic got_last,
                              input logic [WORD_BYTES-1:0] exp_keep, input logic exp_last);
        if (got_keep !== exp_keep || got_last !== exp_last) begin
            $display("MISMATCH %s: got keep 0x%h last 0x%h, expected keep 0x%h last 0x%h",
                     name, got_keep, got_last, exp_keep, exp_last);
            stop_with_failure();
        end
    endtask

    // all bus tasks start and end 1 ns after a rising edge, sampling at the falling edge
    task automatic axil_write(input logic [31:0] addr, input logic [31:0] data,
                              output logic [1:0] resp);
        awaddr  = addr;
        wdata   = data;
        awvalid = 1'b1;
        wvalid  = 1'b1;
        forever begin
            @(negedge clk);
            if (awready && wready) break;
        end
        @(posedge clk);
        #1;
        awvalid = 1'b0;
        wvalid  = 1'b0;
        bready  = 1'b1;
        forever begin
            @(negedge clk);
            if (bvalid) break;
        end
        resp = bresp;
        @(posedge clk);
        #1;
        bready = 1'b0;
    endtask

    task automatic axil_read(input logic [31:0] addr, output logic [31:0] data,
                             output logic [1:0] resp);
        araddr  = addr;
        arvalid = 1'b1;
        forever begin
            @(negedge clk);
            if (arready) break;
        end
        @(posedge clk);
        #1;
        arvalid = 1'b0;
        rready  = 1'b1;
        forever begin
            @(negedge clk);
            if (rvalid) break;
        end
        data = rdata;
        resp = rresp;
        @(posedge clk);
        #1;
        rready = 1'b0;
    endtask

    task automatic push_burst(input int n);
        repeat (n) begin
            stream_data  = next_byte();
            stream_valid = 1'b1;
            forever begin
                @(negedge clk);
                if (stream_ready) break;
            end
            @(posedge clk);
            #1;
            pushed_q.push_back(stream_data);
        end
        stream_valid = 1'b0;
    endtask

    // poll status, pop a word, match kept bytes against the pushed order
    task automatic drain_words();
        logic [31:0]           stat;
        logic [31:0]           data;
        logic [31:0]           exp_data;
        logic [31:0]           mask;
        logic [1:0]            resp;
        logic [WORD_BYTES-1:0] keep;
        logic [WORD_BYTES-1:0] exp_keep;
        int                    nbytes;
        int                    i;
        while (pushed_q.size() > 0) begin
            axil_read(REG_DATA_STAT, stat, resp);
            check_resp("DATA_STAT rresp", resp, RESP_OKAY);
            check_word("DATA_STAT unused bits", stat & ~32'h8000_001F, 32'h0);
            if (stat[STAT_VALID_BIT]) begin
                keep   = stat[STAT_KEEP_LSB +: WORD_BYTES];
                nbytes = $countones(keep);
                if (nbytes > pushed_q.size()) begin
                    $display("word keeps %0d bytes but only %0d remain unread",
                             nbytes, pushed_q.size());
                    stop_with_failure();
                end
                // a valid word holds at least the first byte
                exp_keep = (nbytes == 0) ? WORD_BYTES'(1) : WORD_BYTES'((1 << nbytes) - 1);
                // short words and the final word of a burst carry last
                check_keep("DATA_STAT keep/last", keep, stat[STAT_LAST_BIT], exp_keep,
                           (nbytes < WORD_BYTES) || (nbytes == pushed_q.size()));
                axil_read(REG_DATA_OUT, data, resp);
                check_resp("DATA_OUT rresp", resp, RESP_OKAY);
                exp_data = '0;
                mask     = '0;
                for (i = 0; i < WORD_BYTES; i++) begin
                    if (keep[i]) begin
                        exp_data[8*i +: 8] = pushed_q.pop_front();
                        mask[8*i +: 8]     = 8'hFF;
                    end
                end
                check_word("DATA_OUT", data & mask, exp_data);
                words_popped++;
                if (stat[STAT_LAST_BIT]) lasts_popped++;
            end
        end
    endtask

    task automatic run_bursts();
        repeat (NUM_BURSTS) begin
            push_burst(1 + int'(next_byte()) % 11);
            drain_words();
        end
    endtask

    task automatic fill_and_drain();
        int accepted;
        accepted     = 0;
        stream_data  = next_byte();
        stream_valid = 1'b1;
        forever begin
            @(negedge clk);
            if (!stream_ready) break;
            @(posedge clk);
            #1;
            pushed_q.push_back(stream_data);
            accepted++;
            if (accepted >= FIFO_DEPTH + 5) begin
                $display("stream_ready still high after %0d bytes with no host reads",
                         accepted);
                stop_with_failure();
            end
            stream_data = next_byte();
        end
        // ready drops only once the fifo is full
        if (accepted < FIFO_DEPTH) begin
            $display("stream_ready fell after only %0d bytes were accepted", accepted);
            stop_with_failure();
        end
        @(posedge clk);
        #1;
        stream_valid = 1'b0;
        drain_words();
    endtask

    initial begin
        int cycles;
        cycles = 0;
        while (cycles < CYCLE_LIMIT) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout: no result after %0d cycles", CYCLE_LIMIT);
        stop_with_failure();
    end

    initial begin
        logic [31:0] rd;
        logic [31:0] exp;
        logic [1:0]  resp;
        rst          = 1'b1;
        stream_valid = 1'b0;
        stream_data  = '0;
        awvalid      = 1'b0;
        awaddr       = '0;
        wvalid       = 1'b0;
        wdata        = '0;
        bready       = 1'b0;
        arvalid      = 1'b0;
        araddr       = '0;
        rready       = 1'b0;
        rows = '{
            '{PRE_NONE,   OP_RD, REG_DATA_STAT,  32'h0, RESP_OKAY,   EXP_CONST, 32'h0},
            '{PRE_NONE,   OP_RD, REG_WORD_COUNT, 32'h0, RESP_OKAY,   EXP_CONST, 32'h0},
            '{PRE_NONE,   OP_RD, REG_LAST_COUNT, 32'h0, RESP_OKAY,   EXP_CONST, 32'h0},
            '{PRE_BURSTS, OP_RD, REG_WORD_COUNT, 32'h0, RESP_OKAY,   EXP_WORDS, 32'h0},
            '{PRE_NONE,   OP_RD, REG_LAST_COUNT, 32'h0, RESP_OKAY,   EXP_LASTS, 32'h0},
            '{PRE_NONE,   OP_WR, REG_DATA_STAT,  32'h1, RESP_SLVERR, EXP_CONST, 32'h0},
            '{PRE_NONE,   OP_WR, REG_DATA_OUT,   32'h1, RESP_SLVERR, EXP_CONST, 32'h0},
            '{PRE_NONE,   OP_RD, 32'h14,         32'h0, RESP_SLVERR, EXP_CONST, 32'h0},
            '{PRE_NONE,   OP_RD, REG_WORD_COUNT, 32'h0, RESP_OKAY,   EXP_WORDS, 32'h0},
            '{PRE_NONE,   OP_RD, REG_LAST_COUNT, 32'h0, RESP_OKAY,   EXP_LASTS, 32'h0},
            '{PRE_NONE,   OP_WR, REG_CTRL,       32'h1, RESP_OKAY,   EXP_CONST, 32'h0},
            '{PRE_NONE,   OP_RD, REG_WORD_COUNT, 32'h0, RESP_OKAY,   EXP_CONST, 32'h0},
            '{PRE_NONE,   OP_RD, REG_LAST_COUNT, 32'h0, RESP_OKAY,   EXP_CONST, 32'h0},
            '{PRE_FILL,   OP_RD, REG_WORD_COUNT, 32'h0, RESP_OKAY,   EXP_WORDS, 32'h0},
            '{PRE_NONE,   OP_RD, REG_LAST_COUNT, 32'h0, RESP_OKAY,   EXP_LASTS, 32'h0},
            '{PRE_NONE,   OP_RD, REG_DATA_STAT,  32'h0, RESP_OKAY,   EXP_CONST, 32'h0}
        };
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        rst = 1'b0;
        foreach (rows[i]) begin
            case (rows[i].pre)
                PRE_BURSTS: run_bursts();
                PRE_FILL:   fill_and_drain();
                default:    ;
            endcase
            if (rows[i].op == OP_WR) begin
                axil_write(rows[i].addr, rows[i].wdata, resp);
                check_resp($sformatf("row %0d bresp", i), resp, rows[i].resp);
                if (rows[i].addr == REG_CTRL && rows[i].wdata[CTRL_CLEAR_BIT]) begin
                    words_popped = '0;
                    lasts_popped = '0;
                end
            end else begin
                axil_read(rows[i].addr, rd, resp);
                check_resp($sformatf("row %0d rresp", i), resp, rows[i].resp);
                case (rows[i].kind)
                    EXP_WORDS: exp = 32'(words_popped);
                    EXP_LASTS: exp = 32'(lasts_popped);
                    default:   exp = rows[i].data;
                endcase
                check_word($sformatf("row %0d rdata", i), rd, exp);
            end
        end
        $display("Result: PASSED");
        $finish;
    end

endmodule
